// ==== include/fetch_defines.svh ====
// fetch front end parameters
// queue sizing and the address fetched first after reset

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// instruction queue entries, pointer width must cover the depth
`define FETCH_QUEUE_DEPTH 4
`define FETCH_QUEUE_AW 2

// first fetch address out of reset
`define FETCH_RESET_ADDR 32'h0000_0100

`endif

// ==== rtl/fetch_pkg.sv ====
// fetch front end types
// address, instruction and memory word index vectors shared by the fetch blocks

package fetch_pkg;

	// byte address of an instruction, always word aligned
	typedef logic [31:0] fetch_addr_t;

	// one instruction word as read from memory
	typedef logic [31:0] fetch_inst_t;

	// memory word index, the byte address without bits 1:0
	typedef logic [29:0] fetch_word_idx_t;

endpackage

// ==== rtl/fetch_pc_gen.sv ====
// fetch program counter and read request generator
// issues one instruction memory read per cycle while the queue has room
// and restarts at the target address on a redirect

`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_pc_gen
(
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      redirect_i,
	input  fetch_pkg::fetch_addr_t    redirect_addr_i,
	input  logic                      space_i,
	output logic                      imem_read_o,
	output fetch_pkg::fetch_word_idx_t imem_idx_o,
	output fetch_pkg::fetch_addr_t    req_addr_o
);
	import fetch_pkg::*;

	fetch_addr_t pc_ff;
	logic        run_ff;
	logic        issue;

	// held low through reset, so the first read lands in the first cycle after it
	// a redirect takes this cycle's slot, the target is read in the next one
	assign issue = run_ff && space_i && !redirect_i;

	assign imem_read_o = issue;
	assign imem_idx_o = pc_ff[31:2];
	assign req_addr_o = pc_ff;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			pc_ff <= `FETCH_RESET_ADDR;
			run_ff <= 1'b0;
		end
		else
		begin
			run_ff <= 1'b1;
			if (redirect_i)
			begin
				pc_ff <= redirect_addr_i;
			end
			else if (issue)
			begin
				// next sequential word
				pc_ff <= pc_ff + 32'd4;
			end
		end
	end

endmodule

// ==== rtl/fetch_response.sv ====
// fetch response stage
// pairs each returning memory word with the address that requested it
// and drops the word when a redirect has overtaken the read

`timescale 1ns/1ps

module fetch_response
(
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   redirect_i,
	input  logic                   imem_read_i,
	input  fetch_pkg::fetch_addr_t req_addr_i,
	input  fetch_pkg::fetch_inst_t imem_data_i,
	output logic                   enq_o,
	output logic [63:0]            enq_value_o
);
	import fetch_pkg::*;

	logic        pending_ff;
	fetch_addr_t addr_ff;

	// one read in flight at most per cycle, memory answers in the next one
	// a redirect cancels whatever was issued before it
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			pending_ff <= 1'b0;
		end
		else
		begin
			pending_ff <= imem_read_i && !redirect_i;
		end
	end

	// address of the outstanding read
	always_ff @(posedge clk)
	begin
		if (imem_read_i)
		begin
			addr_ff <= req_addr_i;
		end
	end

	// a redirect in the data cycle makes the word stale
	assign enq_o = pending_ff && !redirect_i;

	// queue entry, address on top and instruction below
	assign enq_value_o = {addr_ff, imem_data_i};

endmodule

// ==== rtl/sync_fifo.sv ====
// synchronous FIFO with flush
// can_enqueue_o looks one cycle ahead: it counts this cycle's enqueue and
// dequeue, so a producer with one cycle of latency never overruns the queue

`timescale 1ns/1ps

module sync_fifo
#(
	parameter int WIDTH = 64,
	parameter int NUM_ENTRIES = 2,
	parameter int ADDR_WIDTH = 1
)
(
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             flush_i,
	output logic             can_enqueue_o,
	input  logic             enqueue_i,
	input  logic [WIDTH-1:0] value_i,
	output logic             can_dequeue_o,
	input  logic             dequeue_i,
	output logic [WIDTH-1:0] value_o
);
	localparam logic [ADDR_WIDTH-1:0] LAST_IDX = ADDR_WIDTH'(NUM_ENTRIES - 1);
	localparam logic [ADDR_WIDTH:0] FULL_COUNT = (ADDR_WIDTH + 1)'(NUM_ENTRIES);

	logic [WIDTH-1:0]      fifo_data [NUM_ENTRIES];
	logic [ADDR_WIDTH-1:0] head_ff;
	logic [ADDR_WIDTH-1:0] head_nxt;
	logic [ADDR_WIDTH-1:0] tail_ff;
	logic [ADDR_WIDTH-1:0] tail_nxt;
	logic [ADDR_WIDTH:0]   count_ff;
	logic [ADDR_WIDTH:0]   count_nxt;

	assign value_o = fifo_data[head_ff];
	assign can_enqueue_o = count_nxt != FULL_COUNT;
	assign can_dequeue_o = count_ff != '0;

	always_comb
	begin
		head_nxt = head_ff;
		tail_nxt = tail_ff;
		count_nxt = count_ff;
		if (flush_i)
		begin
			head_nxt = '0;
			tail_nxt = '0;
			count_nxt = '0;
		end
		else
		begin
			// pointers wrap at the last entry, depth need not be a power of two
			if (enqueue_i)
			begin
				tail_nxt = (tail_ff == LAST_IDX) ? '0 : tail_ff + 1'b1;
			end
			if (dequeue_i)
			begin
				head_nxt = (head_ff == LAST_IDX) ? '0 : head_ff + 1'b1;
			end
			if (enqueue_i && !dequeue_i)
			begin
				count_nxt = count_ff + 1'b1;
			end
			else if (dequeue_i && !enqueue_i)
			begin
				count_nxt = count_ff - 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			head_ff <= '0;
			tail_ff <= '0;
			count_ff <= '0;
		end
		else
		begin
			head_ff <= head_nxt;
			tail_ff <= tail_nxt;
			count_ff <= count_nxt;
		end
	end

	// entry storage, a flush discards the write of the same cycle
	always_ff @(posedge clk)
	begin
		if (enqueue_i && !flush_i)
		begin
			fifo_data[tail_ff] <= value_i;
		end
	end

endmodule

// ==== rtl/fetch_unit.sv ====
// instruction fetch front end
// program counter, memory response pairing and the instruction queue
// feeding decode over a valid/ready handshake

`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_unit
(
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       redirect_i,
	input  fetch_pkg::fetch_addr_t     redirect_addr_i,
	output logic                       imem_read_o,
	output fetch_pkg::fetch_word_idx_t imem_idx_o,
	input  fetch_pkg::fetch_inst_t     imem_data_i,
	output logic                       inst_valid_o,
	output fetch_pkg::fetch_addr_t     inst_addr_o,
	output fetch_pkg::fetch_inst_t     inst_o,
	input  logic                       inst_ready_i
);
	import fetch_pkg::*;

	localparam int ENTRY_WIDTH = $bits(fetch_addr_t) + $bits(fetch_inst_t);

	fetch_addr_t            req_addr;
	logic                   space;
	logic                   enq;
	logic [ENTRY_WIDTH-1:0] enq_value;
	logic [ENTRY_WIDTH-1:0] head_value;
	logic                   deq;

	fetch_pc_gen pc_gen_inst (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.redirect_i      (redirect_i),
		.redirect_addr_i (redirect_addr_i),
		.space_i         (space),
		.imem_read_o     (imem_read_o),
		.imem_idx_o      (imem_idx_o),
		.req_addr_o      (req_addr)
	);

	fetch_response response_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.redirect_i  (redirect_i),
		.imem_read_i (imem_read_o),
		.req_addr_i  (req_addr),
		.imem_data_i (imem_data_i),
		.enq_o       (enq),
		.enq_value_o (enq_value)
	);

	// a redirect empties the queue in the same edge that reloads the pc
	sync_fifo #(
		.WIDTH       (ENTRY_WIDTH),
		.NUM_ENTRIES (`FETCH_QUEUE_DEPTH),
		.ADDR_WIDTH  (`FETCH_QUEUE_AW)
	) queue_inst (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.flush_i       (redirect_i),
		.can_enqueue_o (space),
		.enqueue_i     (enq),
		.value_i       (enq_value),
		.can_dequeue_o (inst_valid_o),
		.dequeue_i     (deq),
		.value_o       (head_value)
	);

	assign deq = inst_valid_o && inst_ready_i;
	assign inst_addr_o = head_value[ENTRY_WIDTH-1:$bits(fetch_inst_t)];
	assign inst_o = head_value[$bits(fetch_inst_t)-1:0];

endmodule

// ==== verif/fetch_assertions.sv ====
// fetch front end protocol checks
// queue overflow and underflow, read gating and decode output stability

`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_assertions
(
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     redirect_i,
	input  logic                     imem_read_i,
	input  logic                     enq_i,
	input  logic                     deq_i,
	input  logic [`FETCH_QUEUE_AW:0] count_i,
	input  logic                     valid_i,
	input  logic                     ready_i,
	input  fetch_pkg::fetch_addr_t   addr_i,
	input  fetch_pkg::fetch_inst_t   inst_i
);

	int                       fail_count = 0;
	logic [`FETCH_QUEUE_AW:0] occ_ff;

	// occupancy rebuilt from the handshakes alone, emptied by a redirect
	always_ff @(posedge clk)
	begin
		if (!rst_n_i || redirect_i)
		begin
			occ_ff <= '0;
		end
		else if (enq_i && !deq_i)
		begin
			occ_ff <= occ_ff + 1'b1;
		end
		else if (deq_i && !enq_i)
		begin
			occ_ff <= occ_ff - 1'b1;
		end
	end

	// a full queue with nothing leaving takes no new read
	read_stops_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
		count_i == `FETCH_QUEUE_DEPTH && !deq_i |-> !imem_read_i)
		else
		begin
			fail_count++;
			$error("memory read issued while the queue was full");
		end

	no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
		enq_i |-> count_i != `FETCH_QUEUE_DEPTH)
		else
		begin
			fail_count++;
			$error("enqueue into a full queue");
		end

	no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
		deq_i |-> occ_ff != 0)
		else
		begin
			fail_count++;
			$error("dequeue from an empty queue");
		end

	// a stalled item holds until it transfers or a redirect flushes it
	hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_i && !ready_i && !redirect_i |=> valid_i && $stable(addr_i) && $stable(inst_i))
		else
		begin
			fail_count++;
			$error("decode output changed while stalled");
		end

endmodule

bind fetch_unit fetch_assertions fetch_assertions_inst (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.redirect_i  (redirect_i),
	.imem_read_i (imem_read_o),
	.enq_i       (enq),
	.deq_i       (deq),
	.count_i     (queue_inst.count_ff),
	.valid_i     (inst_valid_o),
	.ready_i     (inst_ready_i),
	.addr_i      (inst_addr_o),
	.inst_i      (inst_o)
);

// ==== verif/tb_fetch_unit.sv ====
// fetch front end testbench
// memory model, scripted redirects and a randomly stalling decode consumer

`timescale 1ns/1ps
`include "fetch_defines.svh"

module tb_fetch_unit;
	import fetch_pkg::*;

	localparam int MAX_CYCLES = 2000;

	logic            clk;
	logic            rst_n_i;
	logic            redirect_i;
	fetch_addr_t     redirect_addr_i;
	logic            imem_read_o;
	fetch_word_idx_t imem_idx_o;
	fetch_inst_t     imem_data_i;
	logic            inst_valid_o;
	fetch_addr_t     inst_addr_o;
	fetch_inst_t     inst_o;
	logic            inst_ready_i;

	// memory words at 000-0ff and the script from 100 up
	logic [31:0]     image [0:511];
	logic            read_q;
	fetch_word_idx_t idx_q;
	logic [31:0]     lfsr;
	fetch_addr_t     exp_addr;
	int              errors;
	int              timeouts;
	int              assert_fails;
	int              accepted;
	int              total;
	int              redirects;
	int              redir_k;
	int              cycles;

	fetch_unit fetch_unit_inst (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.redirect_i      (redirect_i),
		.redirect_addr_i (redirect_addr_i),
		.imem_read_o     (imem_read_o),
		.imem_idx_o      (imem_idx_o),
		.imem_data_i     (imem_data_i),
		.inst_valid_o    (inst_valid_o),
		.inst_addr_o     (inst_addr_o),
		.inst_o          (inst_o),
		.inst_ready_i    (inst_ready_i)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	// data for the read seen in the previous cycle
	task automatic memory_respond();
		imem_data_i = read_q ? image[{1'b0, idx_q[7:0]}] : '0;
	endtask

	task automatic memory_capture();
		#1;
		read_q = imem_read_o;
		idx_q = imem_idx_o;
	endtask

	task automatic check_transfer();
		fetch_inst_t exp_inst;
		exp_inst = image[{1'b0, exp_addr[9:2]}];
		assert (inst_addr_o == exp_addr)
		else
		begin
			errors++;
			$display("** Error: inst_addr_o is %h, expected %h", inst_addr_o, exp_addr);
		end
		assert (inst_o == exp_inst)
		else
		begin
			errors++;
			$display("** Error: inst_o is %h, expected %h at address %h",
				inst_o, exp_inst, exp_addr);
		end
		accepted++;
		exp_addr = exp_addr + 32'd4;
	endtask

	initial
	begin
		logic b0;
		logic b1;
		clk = 1'b0;
		rst_n_i = 1'b0;
		redirect_i = 1'b0;
		redirect_addr_i = '0;
		imem_data_i = '0;
		inst_ready_i = 1'b0;
		read_q = 1'b0;
		idx_q = '0;
		lfsr = 32'hba17;
		errors = 0;
		timeouts = 0;
		assert_fails = 0;
		accepted = 0;
		redir_k = 0;
		cycles = 0;
		exp_addr = `FETCH_RESET_ADDR;

		// background words for memory the file leaves out
		for (int i = 0; i < 512; i++)
		begin
			image[i] = (i < 256) ? ((32'(i) * 32'h9e37_79b9) ^ 32'h0000_0013) : '0;
		end
		$readmemh("verif/fetch_cases.txt", image);
		total = int'(image[256]);
		redirects = int'(image[257]);

		repeat (3)
		begin
			@(negedge clk);
			memory_respond();
			assert (!inst_valid_o)
			else
			begin
				errors++;
				$display("** Error: inst_valid_o is %h during reset, expected 0", inst_valid_o);
			end
			assert (!imem_read_o)
			else
			begin
				errors++;
				$display("** Error: imem_read_o is %h during reset, expected 0", imem_read_o);
			end
			memory_capture();
		end
		rst_n_i = 1'b1;

		while (accepted < total && cycles < MAX_CYCLES)
		begin
			@(negedge clk);
			cycles++;
			memory_respond();
			redirect_i = 1'b0;
			if (redir_k < redirects && accepted == int'(image[258 + 2 * redir_k]))
			begin
				// ready held low so nothing transfers in the flush edge
				redirect_i = 1'b1;
				redirect_addr_i = image[259 + 2 * redir_k];
				inst_ready_i = 1'b0;
				exp_addr = image[259 + 2 * redir_k];
				redir_k++;
			end
			else
			begin
				take_bit(b0);
				take_bit(b1);
				inst_ready_i = b0 | b1;
				if (inst_valid_o && inst_ready_i)
				begin
					check_transfer();
				end
			end
			memory_capture();
		end

		if (accepted < total)
		begin
			timeouts++;
			$display("timeout: only %0d of %0d instructions accepted in %0d cycles",
				accepted, total, cycles);
		end

		assert_fails = fetch_unit_inst.fetch_assertions_inst.fail_count;
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures, %0d accepted",
			errors, timeouts, assert_fails, accepted);
		if (errors == 0 && timeouts == 0 && assert_fails == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_response.sv
rtl/sync_fifo.sv
rtl/fetch_unit.sv
verif/fetch_assertions.sv
verif/tb_fetch_unit.sv

// ==== Makefile ====
# Verilator build and run for the fetch front end testbench

SIM := obj_dir/Vtb_fetch_unit
SRCS := $(wildcard rtl/*.sv) $(wildcard verif/*.sv) $(wildcard include/*.svh) vlog.f

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) verif/fetch_cases.txt
	verilator --binary --timing --assert -f vlog.f --top-module tb_fetch_unit \
		-o Vtb_fetch_unit

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

// ==== verif/fetch_cases.txt ====
// fetch script for $readmemh: index 000-0ff are memory words, 100 is the total to accept,
// 101 the redirect count, then pairs of (accepted count before redirect, target address)
@040
00000013 00100093 00200113 00300193
00400213 00500293 00600313 00700393
00800413 00900493 00a00513 00b00593
@060
06000013 06100093 06200113 06300193
06400213 06500293 06600313 06700393
@080
08000013 08100093 08200113 08300193
08400213 08500293 08600313 08700393
08800413 08900493 08a00513 08b00593
@0fc
0fc00013 0fd00093 0fe00113 0ff00193
@000
10000013 10100093 10200113 10300193
@100
00000028 00000003
0000000a 00000200
00000014 000003f0
0000001e 00000180
